// ==== verilog.f ====
hw/spu_pkg.sv
hw/instr_decode.sv
hw/register_table.sv
hw/even_pipe.sv
hw/odd_pipe.sv
hw/result_stage.sv
hw/spu_core.sv
verification/spu_core_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= spu_core_tb
FILELIST  ?= verilog.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= All tests passed!

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) > $(LOG) 2>&1; cat $(LOG)
	@if grep -qF '$(PASS_MSG)' $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== verification/spu_core_tb.sv ====
`timescale 1ns/1ps

module spu_core_tb import spu_pkg::*; ();

	localparam int ODD_STAGES = 1;
	localparam logic [31:0] NOP_EVEN = {OPC_NOP, 21'd0};
	localparam logic [31:0] NOP_ODD  = {OPC_LNOP, 21'd0};

	logic         clk = 1'b0;
	logic         reset, issue;
	logic [31:0]  instr_even, instr_odd;
	logic         wb_even_en, wb_odd_en;
	logic [6:0]   wb_even_addr, wb_odd_addr;
	logic [127:0] wb_even_data, wb_odd_data;

	logic [127:0] model [REG_COUNT];		// Expected register contents
	logic         sch_e_en [8], sch_o_en [8];	// Expected write ports per cycle slot
	logic [6:0]   sch_e_addr [8], sch_o_addr [8];
	logic [127:0] sch_e_data [8], sch_o_data [8];
	logic         exp_e_en, exp_o_en;
	logic [6:0]   exp_e_addr, exp_o_addr;
	logic [127:0] exp_e_data, exp_o_data;
	logic [31:0]  pend_e_instr, pend_o_instr;	// Pair being built for the next issue
	logic         pend_e_wr, pend_o_wr;
	logic [6:0]   pend_e_rt, pend_o_rt;
	logic [127:0] pend_e_val, pend_o_val;
	int           cyc = 0;
	int           errors = 0;
	int           tests_passed = 0;
	int           tests_failed = 0;
	spu_op_e      chain_ops [8] = '{OP_A, OP_SF, OP_AND, OP_OR, OP_XOR, OP_CEQ, OP_SELB, OP_CEQ};
	spu_op_e      even_ops [8] = '{OP_IL, OP_A, OP_SF, OP_AND, OP_OR, OP_XOR, OP_CEQ, OP_SELB};
	spu_op_e      odd_ops [2] = '{OP_ROTQBY, OP_SHLQBY};
	int           fixed_counts [4] = '{0, 15, 16, 31};

	spu_core #(.ODD_STAGES(ODD_STAGES)) dut0 (
		.clk(clk), .reset(reset), .issue(issue), .instr_even(instr_even), .instr_odd(instr_odd),
		.wb_even_en(wb_even_en), .wb_even_addr(wb_even_addr), .wb_even_data(wb_even_data),
		.wb_odd_en(wb_odd_en), .wb_odd_addr(wb_odd_addr), .wb_odd_data(wb_odd_data)
	);

	always #4 clk = ~clk;
	always @(posedge clk) cyc <= cyc + 1;

	always_comb begin
		exp_e_en   = sch_e_en[cyc % 8];
		exp_e_addr = sch_e_addr[cyc % 8];
		exp_e_data = sch_e_data[cyc % 8];
		exp_o_en   = sch_o_en[cyc % 8];
		exp_o_addr = sch_o_addr[cyc % 8];
		exp_o_data = sch_o_data[cyc % 8];
	end

	task automatic report_mismatch(input string name, input logic [127:0] expected,
		input logic [127:0] actual);
		$display("CHECK FAILED t=%0t %s expected %0h actual %0h", $time, name, expected, actual);
		errors++;
	endtask

	task automatic report_problem(input string what);
		$display("%s at t=%0t", what, $time);
		errors++;
	endtask

	assert property (@(posedge clk) disable iff (reset) wb_even_en == exp_e_en)
		else report_mismatch("wb_even_en", $sampled(exp_e_en), $sampled(wb_even_en));
	assert property (@(posedge clk) disable iff (reset) wb_even_en |-> wb_even_addr == exp_e_addr)
		else report_mismatch("wb_even_addr", $sampled(exp_e_addr), $sampled(wb_even_addr));
	assert property (@(posedge clk) disable iff (reset) wb_even_en |-> wb_even_data == exp_e_data)
		else report_mismatch("wb_even_data", $sampled(exp_e_data), $sampled(wb_even_data));
	assert property (@(posedge clk) disable iff (reset) wb_odd_en == exp_o_en)
		else report_mismatch("wb_odd_en", $sampled(exp_o_en), $sampled(wb_odd_en));
	assert property (@(posedge clk) disable iff (reset) wb_odd_en |-> wb_odd_addr == exp_o_addr)
		else report_mismatch("wb_odd_addr", $sampled(exp_o_addr), $sampled(wb_odd_addr));
	assert property (@(posedge clk) disable iff (reset) wb_odd_en |-> wb_odd_data == exp_o_data)
		else report_mismatch("wb_odd_data", $sampled(exp_o_data), $sampled(wb_odd_data));
	assert property (@(posedge clk) (reset && cyc > 0) |-> (!wb_even_en && !wb_odd_en))
		else report_problem("Write enable high during reset");
	assert property (@(posedge clk) disable iff (reset)
		(wb_even_en && wb_odd_en) |-> wb_even_addr != wb_odd_addr)
		else report_problem($sformatf("Both write ports name r%0d", $sampled(wb_odd_addr)));

	function automatic logic [10:0] rr_opcode(input spu_op_e op);
		case (op)
			OP_A:      return OPC_A;
			OP_SF:     return OPC_SF;
			OP_AND:    return OPC_AND;
			OP_OR:     return OPC_OR;
			OP_XOR:    return OPC_XOR;
			OP_CEQ:    return OPC_CEQ;
			OP_ROTQBY: return OPC_ROTQBY;
			OP_SHLQBY: return OPC_SHLQBY;
			default:   return OPC_NOP;
		endcase
	endfunction

	function automatic logic [127:0] even_value(input spu_op_e op, input logic [127:0] a,
		input logic [127:0] b, input logic [127:0] c, input logic [15:0] imm);
		logic [127:0] r;
		logic [31:0]  aw, bw, cw, rw;
		for (int w = 0; w < 4; w++) begin
			aw = a[127-32*w -: 32];
			bw = b[127-32*w -: 32];
			cw = c[127-32*w -: 32];
			case (op)
				OP_IL:   rw = {{16{imm[15]}}, imm};
				OP_A:    rw = aw + bw;
				OP_SF:   rw = bw - aw;
				OP_AND:  rw = aw & bw;
				OP_OR:   rw = aw | bw;
				OP_XOR:  rw = aw ^ bw;
				OP_CEQ:  rw = (aw == bw) ? 32'hffffffff : 32'h0;
				OP_SELB: rw = (cw & bw) | (~cw & aw);
				default: rw = 32'h0;
			endcase
			r[127-32*w -: 32] = rw;
		end
		return r;
	endfunction

	// Result byte i takes source byte i+n with byte 0 leftmost
	function automatic logic [127:0] odd_value(input spu_op_e op, input logic [127:0] a,
		input logic [127:0] b);
		logic [127:0] r;
		int           n;
		r = '0;
		n = (op == OP_ROTQBY) ? int'(b[99:96]) : int'(b[100:96]);
		for (int i = 0; i < 16; i++) begin
			if (op == OP_ROTQBY)
				r[127-8*i -: 8] = a[127-8*((i+n)%16) -: 8];
			else if (i + n < 16)
				r[127-8*i -: 8] = a[127-8*(i+n) -: 8];
		end
		return r;
	endfunction

	function automatic logic [6:0] pick_source();
		return 7'(1 + $urandom % 59);
	endfunction

	task automatic put_even(input spu_op_e op, input logic [6:0] rt, input logic [6:0] ra,
		input logic [6:0] rb, input logic [6:0] rc, input logic [15:0] imm);
		if (op == OP_IL)
			pend_e_instr = {OPC_IL, imm, rt};
		else if (op == OP_SELB)
			pend_e_instr = {OPC_SELB, rt, rb, ra, rc};
		else
			pend_e_instr = {rr_opcode(op), rb, ra, rt};
		pend_e_wr  = 1'b1;
		pend_e_rt  = rt;
		pend_e_val = even_value(op, model[ra], model[rb], model[rc], imm);
	endtask

	task automatic put_odd(input spu_op_e op, input logic [6:0] rt, input logic [6:0] ra,
		input logic [6:0] rb);
		pend_o_instr = {rr_opcode(op), rb, ra, rt};
		pend_o_wr    = 1'b1;
		pend_o_rt    = rt;
		pend_o_val   = odd_value(op, model[ra], model[rb]);
	endtask

	// Drives one pair and schedules the writes it must produce
	task automatic issue_pair(input logic do_issue);
		int   slot_e, slot_o;
		logic drop;
		@(negedge clk);
		slot_e = (cyc + 2) % 8;
		slot_o = (cyc + 2 + ODD_STAGES) % 8;
		issue      = do_issue;
		instr_even = pend_e_instr;
		instr_odd  = pend_o_instr;
		drop = sch_o_en[slot_e] && sch_o_addr[slot_e] == pend_e_rt;	// Odd write wins
		sch_e_en[slot_e]   = do_issue && pend_e_wr && !drop;
		sch_e_addr[slot_e] = pend_e_rt;
		sch_e_data[slot_e] = pend_e_val;
		sch_o_en[slot_o]   = do_issue && pend_o_wr;
		sch_o_addr[slot_o] = pend_o_rt;
		sch_o_data[slot_o] = pend_o_val;
		if (sch_e_en[slot_e])
			model[pend_e_rt] = pend_e_val;
		if (sch_o_en[slot_o])
			model[pend_o_rt] = pend_o_val;
		pend_e_instr = NOP_EVEN;
		pend_o_instr = NOP_ODD;
		pend_e_wr    = 1'b0;
		pend_o_wr    = 1'b0;
	endtask

	task automatic idle(input int n);
		repeat (n) issue_pair(1'b0);
	endtask

	task automatic drain(input string what);
		int   i;
		logic busy;
		for (i = 0; i < 16; i++) begin
			issue_pair(1'b0);
			busy = wb_even_en || wb_odd_en;
			for (int s = 0; s < 8; s++)
				busy |= sch_e_en[s] | sch_o_en[s];
			if (!busy)
				break;
		end
		if (i == 16) begin
			$display("Timeout: write ports still busy after 16 cycles in %s", what);
			errors++;
		end
	endtask

	task automatic end_test(input string name, input int errs_at_start);
		if (errors == errs_at_start) begin
			tests_passed++;
			$display("test %s: ok", name);
		end else begin
			tests_failed++;
			$display("test %s: FAILED with %0d errors", name, errors - errs_at_start);
		end
	endtask

	initial begin
		int         errs, n;
		logic [6:0] prev, rt, e_rt, o_rt, last_o_rt;
		logic [6:0] t [4];
		reset = 1'b1;
		issue = 1'b0;
		instr_even = NOP_EVEN;
		instr_odd  = NOP_ODD;
		pend_e_instr = NOP_EVEN;
		pend_o_instr = NOP_ODD;
		pend_e_wr = 1'b0;
		pend_o_wr = 1'b0;
		last_o_rt = '0;
		void'($urandom(32'hb2e0));
		for (int r = 0; r < REG_COUNT; r++)
			model[r] = '0;
		for (int s = 0; s < 8; s++) begin
			sch_e_en[s] = 1'b0;
			sch_o_en[s] = 1'b0;
		end
		repeat (10) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;

		errs = errors;
		idle(3);					// No write may appear yet
		for (int i = 0; i < 14; i++) begin
			rt = (i < 8) ? 7'(1 + i) : pick_source();
			put_even(OP_IL, rt, 7'd0, 7'd0, 7'd0, 16'($urandom));
			issue_pair(1'b1);
		end
		drain("reset and il");
		end_test("reset and il", errs);

		errs = errors;
		put_even(OP_IL, 7'd1, 7'd0, 7'd0, 7'd0, 16'($urandom));
		issue_pair(1'b1);
		put_even(OP_IL, 7'd2, 7'd0, 7'd0, 7'd0, 16'($urandom));
		issue_pair(1'b1);
		idle(1);
		prev = 7'd2;
		for (int i = 0; i < 8; i++) begin
			rt = 7'(10 + i);
			put_even(chain_ops[i], rt, prev, (i == 7) ? prev : 7'(1 + i % 2), 7'd1, 16'd0);
			issue_pair(1'b1);
			idle(1);				// Next one lands on the write edge
			prev = rt;
		end
		drain("even chain");
		end_test("even chain", errs);

		errs = errors;
		put_even(OP_IL, 7'd41, 7'd0, 7'd0, 7'd0, 16'($urandom));
		issue_pair(1'b1);
		put_even(OP_IL, 7'd42, 7'd0, 7'd0, 7'd0, 16'($urandom));
		issue_pair(1'b1);
		put_even(OP_IL, 7'd43, 7'd0, 7'd0, 7'd0, 16'd5);
		issue_pair(1'b1);
		idle(1);
		put_odd(OP_SHLQBY, 7'd44, 7'd41, 7'd43);
		issue_pair(1'b1);
		idle(2);
		put_even(OP_XOR, 7'd40, 7'd44, 7'd42, 7'd0, 16'd0);	// Words now differ
		issue_pair(1'b1);
		idle(1);
		for (int i = 0; i < 10; i++) begin
			n = (i < 4) ? fixed_counts[i] : int'($urandom % 32);
			put_even(OP_IL, 7'd30, 7'd0, 7'd0, 7'd0, 16'(n));
			issue_pair(1'b1);
			idle(1);
			put_odd(OP_ROTQBY, 7'(50 + i), 7'd40, 7'd30);
			issue_pair(1'b1);
			put_odd(OP_SHLQBY, 7'(100 + i), 7'd40, 7'd30);
			issue_pair(1'b1);
		end
		drain("odd byte ops");
		end_test("odd byte ops", errs);

		errs = errors;
		for (int i = 0; i < 32; i++) begin
			e_rt = 7'(64 + $urandom % 63);
			o_rt = 7'(64 + $urandom % 63);
			if (i % 4 == 1)
				o_rt = e_rt;			// Same rt inside one pair
			if (i % 4 == 3)
				e_rt = last_o_rt;		// Meets the previous odd write
			put_even(even_ops[$urandom % 8], e_rt, pick_source(), pick_source(), pick_source(),
				16'($urandom));
			put_odd(odd_ops[$urandom % 2], o_rt, pick_source(), pick_source());
			issue_pair(1'b1);
			last_o_rt = o_rt;
		end
		drain("dual issue");
		end_test("dual issue", errs);

		errs = errors;
		for (int i = 0; i < 4; i++)
			t[i] = 7'(64 + $urandom % 63);
		pend_e_instr = {OPC_ROTQBY, 7'd1, 7'd2, t[0]};	// Odd op in even slot
		pend_o_instr = {OPC_A, 7'd1, 7'd2, t[1]};
		issue_pair(1'b1);
		pend_e_instr = {11'h7ff, 7'd1, 7'd2, t[2]};
		pend_o_instr = {OPC_IL, 16'h1234, t[3]};
		issue_pair(1'b1);
		pend_o_instr = {11'h000, 7'd1, 7'd2, t[0]};
		issue_pair(1'b1);
		drain("wrong slot");
		put_even(OP_A, 7'd61, t[0], 7'd0, 7'd0, 16'd0);
		put_odd(OP_ROTQBY, 7'd62, t[1], 7'd0);
		issue_pair(1'b1);
		put_even(OP_A, 7'd63, t[2], 7'd0, 7'd0, 16'd0);
		put_odd(OP_ROTQBY, 7'd60, t[3], 7'd0);
		issue_pair(1'b1);
		drain("wrong slot readback");
		end_test("wrong slot and unknown", errs);

		$display("tests passed %0d, tests failed %0d, failed checks %0d",
			tests_passed, tests_failed, errors);
		if (errors == 0 && tests_failed == 0)
			$display("All tests passed!");
		else
			$display("Test failures found");
		$finish;
	end

endmodule

// ==== hw/spu_core.sv ====
`timescale 1ns/1ps

module spu_core import spu_pkg::*; #(
	parameter int ODD_STAGES = 1				// Extra odd pipe registers from 1 to 4
) (
	input  logic                     clk,
	input  logic                     reset,
	input  logic                     issue,
	input  logic [0:INSTR_BITS-1]    instr_even,
	input  logic [0:INSTR_BITS-1]    instr_odd,
	output logic                     wb_even_en,
	output logic [0:REG_ADDR_BITS-1] wb_even_addr,
	output logic [0:QWORD_BITS-1]    wb_even_data,
	output logic                     wb_odd_en,
	output logic [0:REG_ADDR_BITS-1] wb_odd_addr,
	output logic [0:QWORD_BITS-1]    wb_odd_data
);

	logic                     even_valid, odd_valid;
	spu_op_e                  even_op, odd_op;
	logic [0:REG_ADDR_BITS-1] even_rt, odd_rt;
	logic [0:IMM_BITS-1]      even_imm;
	logic [0:QWORD_BITS-1]    ra_even, rb_even, rc_even;
	logic [0:QWORD_BITS-1]    ra_odd, rb_odd;
	logic                     ex_even_valid, ex_odd_valid;
	logic [0:REG_ADDR_BITS-1] ex_even_rt, ex_odd_rt;
	logic [0:QWORD_BITS-1]    ex_even_result, ex_odd_result;

	instr_decode decode0 (
		.issue(issue), .instr_even(instr_even), .instr_odd(instr_odd),
		.even_valid(even_valid), .even_op(even_op), .even_rt(even_rt), .even_imm(even_imm),
		.odd_valid(odd_valid), .odd_op(odd_op), .odd_rt(odd_rt)
	);

	// No odd operation reads rc
	register_table regs0 (
		.clk(clk), .reset(reset), .instr_even(instr_even), .instr_odd(instr_odd),
		.ra_even(ra_even), .rb_even(rb_even), .rc_even(rc_even),
		.ra_odd(ra_odd), .rb_odd(rb_odd), .rc_odd(),
		.wb_even_en(wb_even_en), .wb_even_addr(wb_even_addr), .wb_even_data(wb_even_data),
		.wb_odd_en(wb_odd_en), .wb_odd_addr(wb_odd_addr), .wb_odd_data(wb_odd_data)
	);

	even_pipe even0 (
		.clk(clk), .reset(reset), .in_valid(even_valid), .op(even_op), .rt(even_rt),
		.imm(even_imm), .ra(ra_even), .rb(rb_even), .rc(rc_even),
		.out_valid(ex_even_valid), .out_rt(ex_even_rt), .out_result(ex_even_result)
	);

	odd_pipe #(.ODD_STAGES(ODD_STAGES)) odd0 (
		.clk(clk), .reset(reset), .in_valid(odd_valid), .op(odd_op), .rt(odd_rt),
		.ra(ra_odd), .rb(rb_odd),
		.out_valid(ex_odd_valid), .out_rt(ex_odd_rt), .out_result(ex_odd_result)
	);

	result_stage result0 (
		.clk(clk), .reset(reset),
		.even_valid(ex_even_valid), .even_rt(ex_even_rt), .even_result(ex_even_result),
		.odd_valid(ex_odd_valid), .odd_rt(ex_odd_rt), .odd_result(ex_odd_result),
		.wb_even_en(wb_even_en), .wb_even_addr(wb_even_addr), .wb_even_data(wb_even_data),
		.wb_odd_en(wb_odd_en), .wb_odd_addr(wb_odd_addr), .wb_odd_data(wb_odd_data)
	);

endmodule

// ==== hw/result_stage.sv ====
`timescale 1ns/1ps

module result_stage import spu_pkg::*; (
	input  logic                     clk,
	input  logic                     reset,
	input  logic                     even_valid,
	input  logic [0:REG_ADDR_BITS-1] even_rt,
	input  logic [0:QWORD_BITS-1]    even_result,
	input  logic                     odd_valid,
	input  logic [0:REG_ADDR_BITS-1] odd_rt,
	input  logic [0:QWORD_BITS-1]    odd_result,
	output logic                     wb_even_en,
	output logic [0:REG_ADDR_BITS-1] wb_even_addr,
	output logic [0:QWORD_BITS-1]    wb_even_data,
	output logic                     wb_odd_en,
	output logic [0:REG_ADDR_BITS-1] wb_odd_addr,
	output logic [0:QWORD_BITS-1]    wb_odd_data
);

	logic same_rt;

	assign same_rt = odd_valid && (odd_rt == even_rt);	// Odd write wins the register

	always_ff @(posedge clk) begin
		if (reset) begin
			wb_even_en <= 1'b0;
			wb_odd_en  <= 1'b0;
		end else begin
			wb_even_en <= even_valid && !same_rt;
			wb_odd_en  <= odd_valid;
		end
	end

	always_ff @(posedge clk) begin
		wb_even_addr <= even_rt;
		wb_even_data <= even_result;
		wb_odd_addr  <= odd_rt;
		wb_odd_data  <= odd_result;
	end

endmodule

// ==== hw/odd_pipe.sv ====
`timescale 1ns/1ps

module odd_pipe import spu_pkg::*; #(
	parameter int ODD_STAGES = 1
) (
	input  logic                     clk,
	input  logic                     reset,
	input  logic                     in_valid,
	input  spu_op_e                  op,
	input  logic [0:REG_ADDR_BITS-1] rt,
	input  logic [0:QWORD_BITS-1]    ra,
	input  logic [0:QWORD_BITS-1]    rb,
	output logic                     out_valid,
	output logic [0:REG_ADDR_BITS-1] out_rt,
	output logic [0:QWORD_BITS-1]    out_result
);

	logic                     valid_q;
	spu_op_e                  op_q;
	logic [0:REG_ADDR_BITS-1] rt_q;
	logic [0:QWORD_BITS-1]    ra_q, rb_q;
	logic [0:QWORD_BITS-1]    result;
	logic [3:0]               rot_count;		// rb word 0, bits 28-31
	logic [4:0]               shl_count;		// rb word 0, bits 27-31

	logic                     stg_valid [ODD_STAGES];
	logic [0:REG_ADDR_BITS-1] stg_rt [ODD_STAGES];
	logic [0:QWORD_BITS-1]    stg_result [ODD_STAGES];

	always_ff @(posedge clk) begin
		if (reset)
			valid_q <= 1'b0;
		else
			valid_q <= in_valid;
	end

	always_ff @(posedge clk) begin
		op_q <= op;
		rt_q <= rt;
		ra_q <= ra;
		rb_q <= rb;
	end

	// Byte 0 is the leftmost byte, so a left move goes toward bit 0
	always_comb begin
		rot_count = rb_q[28:31];
		shl_count = rb_q[27:31];
		case (op_q)
			OP_ROTQBY: result = (ra_q << {rot_count, 3'b000}) |
				(ra_q >> (8'd128 - {1'b0, rot_count, 3'b000}));
			OP_SHLQBY: result = shl_count[4] ? '0 : (ra_q << {shl_count[3:0], 3'b000});
			default:   result = '0;
		endcase
	end

	// Stage chain, first stage takes the computed result
	always_ff @(posedge clk) begin
		if (reset) begin
			for (int s = 0; s < ODD_STAGES; s++)
				stg_valid[s] <= 1'b0;
		end else begin
			stg_valid[0] <= valid_q;
			for (int s = 1; s < ODD_STAGES; s++)
				stg_valid[s] <= stg_valid[s-1];
		end
	end

	always_ff @(posedge clk) begin
		stg_rt[0]     <= rt_q;
		stg_result[0] <= result;
		for (int s = 1; s < ODD_STAGES; s++) begin
			stg_rt[s]     <= stg_rt[s-1];
			stg_result[s] <= stg_result[s-1];
		end
	end

	assign out_valid  = stg_valid[ODD_STAGES-1];
	assign out_rt     = stg_rt[ODD_STAGES-1];
	assign out_result = stg_result[ODD_STAGES-1];

	assert property (@(posedge clk) disable iff (reset)
		in_valid |-> (op inside {OP_ROTQBY, OP_SHLQBY}))
	else
		$error("odd_pipe: valid issue with non-odd op %s", op.name());

endmodule

// ==== hw/even_pipe.sv ====
`timescale 1ns/1ps

module even_pipe import spu_pkg::*; (
	input  logic                     clk,
	input  logic                     reset,
	input  logic                     in_valid,
	input  spu_op_e                  op,
	input  logic [0:REG_ADDR_BITS-1] rt,
	input  logic [0:IMM_BITS-1]      imm,
	input  logic [0:QWORD_BITS-1]    ra,
	input  logic [0:QWORD_BITS-1]    rb,
	input  logic [0:QWORD_BITS-1]    rc,
	output logic                     out_valid,
	output logic [0:REG_ADDR_BITS-1] out_rt,
	output logic [0:QWORD_BITS-1]    out_result
);

	logic                     valid_q;
	spu_op_e                  op_q;
	logic [0:REG_ADDR_BITS-1] rt_q;
	logic [0:IMM_BITS-1]      imm_q;
	logic [0:QWORD_BITS-1]    ra_q, rb_q, rc_q;

	always_ff @(posedge clk) begin
		if (reset)
			valid_q <= 1'b0;
		else
			valid_q <= in_valid;
	end

	always_ff @(posedge clk) begin
		op_q  <= op;
		rt_q  <= rt;
		imm_q <= imm;
		ra_q  <= ra;
		rb_q  <= rb;
		rc_q  <= rc;
	end

	always_comb begin
		logic [WORD_BITS-1:0] a_w, b_w, c_w, imm_ext, r_w;
		imm_ext = {{(WORD_BITS-IMM_BITS){imm_q[0]}}, imm_q};	// Sign-extended il value
		out_result = '0;
		for (int w = 0; w < QWORD_BITS/WORD_BITS; w++) begin
			a_w = ra_q[w*WORD_BITS +: WORD_BITS];
			b_w = rb_q[w*WORD_BITS +: WORD_BITS];
			c_w = rc_q[w*WORD_BITS +: WORD_BITS];
			case (op_q)
				OP_IL:   r_w = imm_ext;
				OP_A:    r_w = a_w + b_w;
				OP_SF:   r_w = b_w - a_w;			// Subtract from, rb minus ra
				OP_AND:  r_w = a_w & b_w;
				OP_OR:   r_w = a_w | b_w;
				OP_XOR:  r_w = a_w ^ b_w;
				OP_CEQ:  r_w = (a_w == b_w) ? '1 : '0;
				OP_SELB: r_w = (c_w & b_w) | (~c_w & a_w);	// rc picks rb bits
				default: r_w = '0;
			endcase
			out_result[w*WORD_BITS +: WORD_BITS] = r_w;
		end
	end

	assign out_valid = valid_q;
	assign out_rt    = rt_q;

	// Decode must never route an odd or empty operation here
	assert property (@(posedge clk) disable iff (reset)
		in_valid |-> (op inside {OP_IL, OP_A, OP_SF, OP_AND, OP_OR, OP_XOR, OP_CEQ, OP_SELB}))
	else
		$error("even_pipe: valid issue with non-even op %s", op.name());

endmodule

// ==== hw/register_table.sv ====
`timescale 1ns/1ps

module register_table import spu_pkg::*; (
	input  logic                     clk,
	input  logic                     reset,
	input  logic [0:INSTR_BITS-1]    instr_even,
	input  logic [0:INSTR_BITS-1]    instr_odd,
	output logic [0:QWORD_BITS-1]    ra_even,
	output logic [0:QWORD_BITS-1]    rb_even,
	output logic [0:QWORD_BITS-1]    rc_even,
	output logic [0:QWORD_BITS-1]    ra_odd,
	output logic [0:QWORD_BITS-1]    rb_odd,
	output logic [0:QWORD_BITS-1]    rc_odd,
	input  logic                     wb_even_en,
	input  logic [0:REG_ADDR_BITS-1] wb_even_addr,
	input  logic [0:QWORD_BITS-1]    wb_even_data,
	input  logic                     wb_odd_en,
	input  logic [0:REG_ADDR_BITS-1] wb_odd_addr,
	input  logic [0:QWORD_BITS-1]    wb_odd_data
);

	logic [0:QWORD_BITS-1] regs [REG_COUNT];

	// One read port with forwarding from both write ports, odd checked last
	function automatic logic [0:QWORD_BITS-1] read_port(input logic [0:REG_ADDR_BITS-1] addr);
		logic [0:QWORD_BITS-1] value;
		value = regs[addr];
		if (wb_even_en && wb_even_addr == addr)
			value = wb_even_data;
		if (wb_odd_en && wb_odd_addr == addr)
			value = wb_odd_data;
		return value;
	endfunction

	// Source fields are read whatever the format
	always_comb begin
		rb_even = read_port(instr_even[11:17]);
		ra_even = read_port(instr_even[18:24]);
		rc_even = read_port(instr_even[25:31]);

		rb_odd  = read_port(instr_odd[11:17]);
		ra_odd  = read_port(instr_odd[18:24]);
		rc_odd  = read_port(instr_odd[25:31]);
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < REG_COUNT; i++)
				regs[i] <= '0;
		end else begin
			if (wb_even_en)
				regs[wb_even_addr] <= wb_even_data;
			if (wb_odd_en)
				regs[wb_odd_addr] <= wb_odd_data;	// Odd wins on a shared address
		end
	end

	// The result stage must resolve same-register writes before they get here
	assert property (@(posedge clk) disable iff (reset)
		!(wb_even_en && wb_odd_en && wb_even_addr == wb_odd_addr))
	else
		$error("register_table: both write ports target r%0d", wb_even_addr);

endmodule

// ==== hw/instr_decode.sv ====
`timescale 1ns/1ps

module instr_decode import spu_pkg::*; (
	input  logic                     issue,
	input  logic [0:INSTR_BITS-1]    instr_even,
	input  logic [0:INSTR_BITS-1]    instr_odd,
	output logic                     even_valid,
	output spu_op_e                  even_op,
	output logic [0:REG_ADDR_BITS-1] even_rt,
	output logic [0:IMM_BITS-1]      even_imm,
	output logic                     odd_valid,
	output spu_op_e                  odd_op,
	output logic [0:REG_ADDR_BITS-1] odd_rt
);

	instr_format_e fmt_even, fmt_odd;
	spu_op_e       dec_even, dec_odd;

	// Longest match last, RRR opcode is checked first
	function automatic instr_format_e instr_format(input logic [0:INSTR_BITS-1] instr);
		if (instr[0:3] == OPC_SELB)
			return RRR;
		else if (instr[0:8] == OPC_IL)
			return RI16;
		else
			return RR;
	endfunction

	function automatic spu_op_e instr_op(input logic [0:INSTR_BITS-1] instr);
		spu_op_e op;
		op = OP_NOP;
		if (instr[0:3] == OPC_SELB)
			op = OP_SELB;
		else if (instr[0:8] == OPC_IL)
			op = OP_IL;
		else begin
			case (instr[0:10])
				OPC_A:      op = OP_A;
				OPC_SF:     op = OP_SF;
				OPC_AND:    op = OP_AND;
				OPC_OR:     op = OP_OR;
				OPC_XOR:    op = OP_XOR;
				OPC_CEQ:    op = OP_CEQ;
				OPC_ROTQBY: op = OP_ROTQBY;
				OPC_SHLQBY: op = OP_SHLQBY;
				OPC_NOP:    op = OP_NOP;
				OPC_LNOP:   op = OP_NOP;
				default:    op = OP_NOP;		// Unknown opcode writes nothing
			endcase
		end
		return op;
	endfunction

	always_comb begin
		fmt_even = instr_format(instr_even);
		fmt_odd  = instr_format(instr_odd);
		dec_even = instr_op(instr_even);
		dec_odd  = instr_op(instr_odd);

		// Only operations that belong to the slot's pipe are kept
		even_valid = issue && (dec_even inside {OP_IL, OP_A, OP_SF, OP_AND, OP_OR,
			OP_XOR, OP_CEQ, OP_SELB});
		odd_valid  = issue && (dec_odd inside {OP_ROTQBY, OP_SHLQBY});

		even_op  = even_valid ? dec_even : OP_NOP;
		odd_op   = odd_valid ? dec_odd : OP_NOP;

		even_rt  = (fmt_even == RRR) ? instr_even[4:10] : instr_even[25:31];
		odd_rt   = (fmt_odd == RRR) ? instr_odd[4:10] : instr_odd[25:31];
		even_imm = instr_even[9:24];				// Only used by il
	end

endmodule

// ==== hw/spu_pkg.sv ====
package spu_pkg;

	localparam int QWORD_BITS    = 128;			// Register and operand width
	localparam int WORD_BITS     = 32;			// Word lane inside a quadword
	localparam int INSTR_BITS    = 32;			// Bits numbered 0 to 31 from the left
	localparam int REG_ADDR_BITS = 7;
	localparam int REG_COUNT     = 128;
	localparam int IMM_BITS      = 16;			// RI16 immediate field

	// Instruction formats, source fields sit at 11-17, 18-24 and 25-31 in all of them
	typedef enum logic [1:0] {
		RR   = 2'd0,							// op 0-10, rb 11-17, ra 18-24, rt 25-31
		RRR  = 2'd1,							// op 0-3, rt 4-10, rb 11-17, ra 18-24, rc 25-31
		RI16 = 2'd2								// op 0-8, imm 9-24, rt 25-31
	} instr_format_e;

	typedef enum logic [3:0] {
		OP_NOP    = 4'd0,
		OP_IL     = 4'd1,
		OP_A      = 4'd2,
		OP_SF     = 4'd3,
		OP_AND    = 4'd4,
		OP_OR     = 4'd5,
		OP_XOR    = 4'd6,
		OP_CEQ    = 4'd7,
		OP_SELB   = 4'd8,
		OP_ROTQBY = 4'd9,
		OP_SHLQBY = 4'd10
	} spu_op_e;

	// RR opcodes, bits 0-10
	localparam logic [0:10] OPC_A      = 11'b00011000000;
	localparam logic [0:10] OPC_SF     = 11'b00001000000;
	localparam logic [0:10] OPC_AND    = 11'b00011000001;
	localparam logic [0:10] OPC_OR     = 11'b00001000001;
	localparam logic [0:10] OPC_XOR    = 11'b01001000001;
	localparam logic [0:10] OPC_CEQ    = 11'b01111000000;
	localparam logic [0:10] OPC_ROTQBY = 11'b00111011100;
	localparam logic [0:10] OPC_SHLQBY = 11'b00111011111;
	localparam logic [0:10] OPC_NOP    = 11'b01000000001;	// Even slot no-op
	localparam logic [0:10] OPC_LNOP   = 11'b00000000001;	// Odd slot no-op

	// RRR opcode, bits 0-3
	localparam logic [0:3]  OPC_SELB   = 4'b1000;

	// RI16 opcode, bits 0-8
	localparam logic [0:8]  OPC_IL     = 9'b010000001;

endpackage
